//--- source/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	// datapath and reorder-buffer widths
	localparam int word_width = 16;
	localparam int rob_addr_width = 3;

	typedef logic [word_width-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [rob_addr_width-1:0] lc3b_rob_addr;

	// bit 2 is n, bit 1 is z, bit 0 is p
	typedef logic [2:0] lc3b_nzp;

	// standard LC-3b opcode encoding
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// the rob dest field holds a register number, except for BR where
	// it carries the nzp mask of the instruction
	typedef union packed {
		lc3b_reg rnum;
		lc3b_nzp nzp;
	} lc3b_dest;

	// how the head entry is retired
	typedef enum logic [2:0] {
		cls_branch,
		cls_alu,
		cls_indirect_load,
		cls_indirect_store,
		cls_link,
		cls_store,
		cls_trap,
		cls_none
	} commit_class;

	// codes after reset read as zero
	localparam lc3b_nzp cc_reset_value = 3'b010;

endpackage : lc3b_pkg

`default_nettype wire

//--- source/commit_decode.sv
`default_nettype none

module commit_decode
	import lc3b_pkg::*;
(
	input  lc3b_opcode  opcode,
	output commit_class cls,
	output logic        writes_reg,
	output logic        sets_cc,
	output logic        redirects
);

	always_comb
	begin
		cls = cls_none;
		writes_reg = 1'b0;
		sets_cc = 1'b0;
		redirects = 1'b0;
		case (opcode)
			op_br:
			begin
				cls = cls_branch;
				// only taken on a misprediction
				redirects = 1'b1;
			end
			op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb:
			begin
				cls = cls_alu;
				writes_reg = 1'b1;
				sets_cc = 1'b1;
			end
			op_ldi:
			begin
				// flags apply to the second entry only
				cls = cls_indirect_load;
				writes_reg = 1'b1;
				sets_cc = 1'b1;
			end
			op_sti:
			begin
				cls = cls_indirect_store;
			end
			op_jsr:
			begin
				// link register write leaves the codes alone
				cls = cls_link;
				writes_reg = 1'b1;
			end
			op_str, op_stb:
			begin
				cls = cls_store;
			end
			op_trap:
			begin
				cls = cls_trap;
				writes_reg = 1'b1;
				redirects = 1'b1;
			end
			// rti and jmp have nothing to commit here
			default:
			begin
				cls = cls_none;
			end
		endcase
	end

endmodule : commit_decode

`default_nettype wire

//--- source/cc_unit.sv
`default_nettype none

module cc_unit
	import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  lc3b_word value,
	input  logic     ld_cc,
	input  lc3b_dest dest,
	output logic     branch_taken
);

	lc3b_nzp gen_cc;
	lc3b_nzp cc;

	// n from the sign bit, z when all zero, p otherwise
	always_comb
	begin
		if (value[word_width-1])
		begin
			gen_cc = 3'b100;
		end
		else if (value == '0)
		begin
			gen_cc = 3'b010;
		end
		else
		begin
			gen_cc = 3'b001;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cc <= cc_reset_value;
		end
		else if (ld_cc)
		begin
			cc <= gen_cc;
		end
	end

	// any flag selected by the branch mask makes it taken
	assign branch_taken = |(cc & dest.nzp);

endmodule : cc_unit

`default_nettype wire

//--- source/commit_control.sv
`default_nettype none

module commit_control
	import lc3b_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         valid,
	input  commit_class  cls,
	input  logic         writes_reg,
	input  logic         sets_cc,
	input  logic         redirects,
	input  logic         branch_taken,
	input  logic         predict,
	input  lc3b_rob_addr tag_of_dest,
	input  lc3b_rob_addr rob_addr,
	input  logic         dmem_resp,
	output logic         ld_regfile_value,
	output logic         ld_regfile_busy,
	output logic         ld_cc,
	output logic         retire,
	output logic         flush,
	output logic         pcmux_sel,
	output logic         dmem_write,
	output logic         ldstr_retire,
	output logic         use_trap_value
);

	// 0 while waiting for the first ldi/sti entry, 1 for the second
	logic phase;
	logic indirect;
	logic write_result;
	logic store_access;
	logic redirect;
	logic head_retire;

	assign indirect = (cls == cls_indirect_load) || (cls == cls_indirect_store);

	always_comb
	begin
		write_result = 1'b0;
		store_access = 1'b0;
		redirect = 1'b0;
		head_retire = 1'b0;
		if (valid)
		begin
			case (cls)
				cls_branch:
				begin
					head_retire = 1'b1;
					redirect = redirects && (branch_taken != predict);
				end
				cls_alu, cls_link, cls_trap:
				begin
					head_retire = 1'b1;
					write_result = writes_reg;
					redirect = redirects;
				end
				cls_indirect_load:
				begin
					// first entry only fetches the pointer
					head_retire = 1'b1;
					write_result = writes_reg && phase;
				end
				cls_indirect_store:
				begin
					if (phase)
					begin
						store_access = 1'b1;
					end
					else
					begin
						head_retire = 1'b1;
					end
				end
				cls_store:
				begin
					store_access = 1'b1;
				end
				default:
				begin
					head_retire = 1'b0;
				end
			endcase
		end
	end

	// register file and cc loads
	assign ld_regfile_value = write_result;
	// busy only clears if no younger entry has renamed the register
	assign ld_regfile_busy = write_result && (tag_of_dest == rob_addr);
	assign ld_cc = write_result && sets_cc;

	// stores hold the head until memory answers
	assign dmem_write = store_access;
	assign ldstr_retire = store_access && dmem_resp;
	assign retire = head_retire || (store_access && dmem_resp);

	assign flush = redirect;
	assign pcmux_sel = redirect;

	// selects trap_reg as the link value
	assign use_trap_value = (cls == cls_trap);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 1'b0;
		end
		else if (valid && retire && indirect)
		begin
			phase <= ~phase;
		end
	end

endmodule : commit_control

`default_nettype wire

//--- source/commit_stage.sv
`default_nettype none

module commit_stage
	import lc3b_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// reorder buffer head
	input  logic         valid,
	input  lc3b_opcode   opcode,
	input  lc3b_dest     dest,
	input  lc3b_word     value,
	input  logic         predict,
	input  lc3b_rob_addr tag_of_dest,
	input  lc3b_rob_addr rob_addr,
	input  logic         dmem_resp,
	input  lc3b_word     trap_reg,

	// register file
	output lc3b_reg      dest_a,
	output lc3b_word     value_out,
	output logic         ld_regfile_value,
	output logic         ld_regfile_busy,
	output lc3b_reg      dest_wr,

	output logic         retire,
	output logic         flush,

	// fetch
	output logic         pcmux_sel,
	output lc3b_word     new_pc,

	output logic         dmem_write,
	output logic         ldstr_retire
);

	commit_class cls;
	logic writes_reg;
	logic sets_cc;
	logic redirects;
	logic branch_taken;
	logic ld_cc;
	logic use_trap_value;

	assign dest_a = dest.rnum;
	assign dest_wr = dest.rnum;
	// branch and trap targets arrive in the value field
	assign new_pc = value;
	assign value_out = use_trap_value ? trap_reg : value;

	commit_decode decode0 (
		.opcode     (opcode),
		.cls        (cls),
		.writes_reg (writes_reg),
		.sets_cc    (sets_cc),
		.redirects  (redirects)
	);

	cc_unit cc0 (
		.clk          (clk),
		.reset        (reset),
		.value        (value),
		.ld_cc        (ld_cc),
		.dest         (dest),
		.branch_taken (branch_taken)
	);

	commit_control control0 (
		.clk              (clk),
		.reset            (reset),
		.valid            (valid),
		.cls              (cls),
		.writes_reg       (writes_reg),
		.sets_cc          (sets_cc),
		.redirects        (redirects),
		.branch_taken     (branch_taken),
		.predict          (predict),
		.tag_of_dest      (tag_of_dest),
		.rob_addr         (rob_addr),
		.dmem_resp        (dmem_resp),
		.ld_regfile_value (ld_regfile_value),
		.ld_regfile_busy  (ld_regfile_busy),
		.ld_cc            (ld_cc),
		.retire           (retire),
		.flush            (flush),
		.pcmux_sel        (pcmux_sel),
		.dmem_write       (dmem_write),
		.ldstr_retire     (ldstr_retire),
		.use_trap_value   (use_trap_value)
	);

endmodule : commit_stage

`default_nettype wire

//--- sim/commit_checker.sv
`default_nettype none

module commit_checker
	import lc3b_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         valid,
	input  lc3b_opcode   opcode,
	input  lc3b_dest     dest,
	input  lc3b_word     value,
	input  logic         predict,
	input  lc3b_rob_addr tag_of_dest,
	input  lc3b_rob_addr rob_addr,
	input  logic         dmem_resp,
	input  lc3b_word     trap_reg,
	input  lc3b_reg      dest_a,
	input  lc3b_word     value_out,
	input  logic         ld_regfile_value,
	input  logic         ld_regfile_busy,
	input  lc3b_reg      dest_wr,
	input  logic         retire,
	input  logic         flush,
	input  logic         pcmux_sel,
	input  lc3b_word     new_pc,
	input  logic         dmem_write,
	input  logic         ldstr_retire,
	input  logic         report,
	output int           error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// error buckets for writeback, branch, store, indirect, trap and idle
	int errors [6] = '{0, 0, 0, 0, 0, 0};
	int total = 0;
	lc3b_nzp cc = cc_reset_value;
	logic phase = 1'b0;
	logic reported = 1'b0;

	assign error_count = total;

	// {ld_value, ld_busy, retire, flush, pcmux_sel, dmem_write, ldstr_retire, ld_cc, toggle}
	function automatic logic [8:0] expected_strobes(input logic vld, input lc3b_opcode op,
		input logic ph, input lc3b_nzp codes, input lc3b_nzp mask, input logic pred,
		input logic tag_match, input logic resp);
		logic alu;
		logic wr;
		logic st;
		logic ret;
		logic redirect;
		alu = op inside {op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb};
		wr = vld && (alu || op == op_jsr || op == op_trap || (op == op_ldi && ph));
		st = vld && (op == op_str || op == op_stb || (op == op_sti && ph));
		ret = (vld && (op == op_br || op == op_ldi || (op == op_sti && !ph))) || wr;
		ret = ret || (st && resp);
		redirect = vld && ((op == op_br && (|(codes & mask)) != pred) || op == op_trap);
		return {wr, wr && tag_match, ret, redirect, redirect, st, st && resp,
			wr && (alu || op == op_ldi), ret && (op == op_ldi || op == op_sti)};
	endfunction

	function automatic lc3b_nzp codes_of(input lc3b_word v);
		if (v[word_width-1])
			return 3'b100;
		else if (v == '0)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic int bucket_of(input logic rst, input logic vld, input lc3b_opcode op);
		if (rst || !vld)
			return 5;
		case (op)
			op_br: return 1;
			op_str, op_stb: return 2;
			op_ldi, op_sti: return 3;
			op_trap: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic string strobe_name(input int i);
		case (i)
			8: return "ld_regfile_value";
			7: return "ld_regfile_busy";
			6: return "retire";
			5: return "flush";
			4: return "pcmux_sel";
			3: return "dmem_write";
			default: return "ldstr_retire";
		endcase
	endfunction

	task automatic report_mismatch(input string name, input lc3b_word got, input lc3b_word want,
		input int bucket);
		$display("error at %0d ns: %s expected %h, got %h (opcode %s, phase %0d)",
			$time, name, want, got, opcode.name(), phase);
		errors[bucket] = errors[bucket] + 1;
		total = total + 1;
	endtask

	always @(posedge clk)
	begin
		logic [8:0] want;
		logic [8:0] seen;
		lc3b_word want_value;
		int b;
		want = expected_strobes(valid && !reset, opcode, phase, cc, dest.nzp, predict,
			tag_of_dest == rob_addr, dmem_resp);
		seen = {ld_regfile_value, ld_regfile_busy, retire, flush, pcmux_sel, dmem_write,
			ldstr_retire, 2'b00};
		b = bucket_of(reset, valid, opcode);
		for (int i = 2; i < 9; i++)
		begin
			if (seen[i] !== want[i])
			begin
				report_mismatch(strobe_name(i), 16'(seen[i]), 16'(want[i]), b);
			end
		end
		if (valid && !reset)
		begin
			// trap writes the link value from trap_reg
			want_value = (opcode == op_trap) ? trap_reg : value;
			if (value_out !== want_value)
				report_mismatch("value_out", value_out, want_value, b);
			if (new_pc !== value)
				report_mismatch("new_pc", new_pc, value, b);
			if (dest_a !== dest.rnum || dest_wr !== dest.rnum)
				report_mismatch("dest_a/dest_wr", 16'(dest_a), 16'(dest.rnum), b);
		end
		// mirrored cc register and indirect phase
		if (reset)
		begin
			cc = cc_reset_value;
			phase = 1'b0;
		end
		else
		begin
			if (want[1])
				cc = codes_of(value);
			if (want[0])
				phase = ~phase;
		end
		if (report && !reported)
		begin
			$display("error counts: writeback %0d, branch %0d, store %0d, indirect %0d, %s%0d, %s%0d",
				errors[0], errors[1], errors[2], errors[3], "trap ", errors[4], "idle ", errors[5]);
			reported = 1'b1;
		end
	end

endmodule : commit_checker

`default_nettype wire

//--- sim/tb_commit_stage.sv
`default_nettype none

module tb_commit_stage
	import lc3b_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_entries = 300;
	// a store holds the head for at most five cycles and most entries take one
	localparam int timeout_cycles = 4 * num_entries;

	logic clk;
	logic reset;
	logic valid;
	lc3b_opcode opcode;
	lc3b_dest dest;
	lc3b_word value;
	logic predict;
	lc3b_rob_addr tag_of_dest;
	lc3b_rob_addr rob_addr;
	logic dmem_resp;
	lc3b_word trap_reg;
	lc3b_reg dest_a;
	lc3b_word value_out;
	logic ld_regfile_value;
	logic ld_regfile_busy;
	lc3b_reg dest_wr;
	logic retire;
	logic flush;
	logic pcmux_sel;
	lc3b_word new_pc;
	logic dmem_write;
	logic ldstr_retire;

	logic report;
	int error_count;
	logic [31:0] seed;
	logic took = 1'b0;
	int retired_count = 0;
	int cycle_count = 0;
	int wait_left;
	logic pending_second;
	lc3b_opcode pending_op;

	commit_stage dut0 (.*);

	commit_checker checker0 (.*);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_rand(output lc3b_word r);
		seed = lcg_step(seed);
		r = seed[30:15];
	endtask

	// new head entry or now and then a bubble
	task automatic present_entry();
		lc3b_word r;
		lc3b_word w;
		next_rand(r);
		valid = pending_second || (r[2:0] != 3'd0);
		if (pending_second)
		begin
			// second half of an ldi or sti pair
			opcode = pending_op;
			pending_second = 1'b0;
		end
		else
		begin
			opcode = lc3b_opcode'(r[6:3]);
			// rti and jmp have no commit action
			if (opcode == op_rti || opcode == op_jmp)
			begin
				opcode = op_br;
			end
			pending_second = valid && (opcode == op_ldi || opcode == op_sti);
			pending_op = opcode;
		end
		dest.rnum = r[9:7];
		predict = r[10];
		rob_addr = r[13:11];
		next_rand(w);
		value = (r[15:14] == 2'b00) ? '0 : w;
		next_rand(w);
		trap_reg = w;
		next_rand(w);
		tag_of_dest = w[0] ? rob_addr : w[3:1];
		// memory answers after 0 to 4 cycles
		wait_left = int'(w[6:4]) % 5;
		dmem_resp = (wait_left == 0);
	endtask

	task automatic hold_entry();
		if (wait_left > 0)
		begin
			wait_left = wait_left - 1;
		end
		dmem_resp = (wait_left == 0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		took <= valid && retire;
		if (valid && retire)
		begin
			retired_count <= retired_count + 1;
		end
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: the test did not finish within %0d cycles", timeout_cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		seed = 32'd49980;
		reset = 1'b1;
		valid = 1'b0;
		opcode = op_br;
		dest = '0;
		value = '0;
		predict = 1'b0;
		tag_of_dest = '0;
		rob_addr = '0;
		dmem_resp = 1'b0;
		trap_reg = '0;
		report = 1'b0;
		pending_second = 1'b0;
		pending_op = op_br;
		wait_left = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// branch on z predicted not taken mispredicts with the reset codes
		valid = 1'b1;
		dest.nzp = 3'b010;
		predict = 1'b0;
		while (retired_count < num_entries)
		begin
			@(negedge clk);
			if (!valid || took)
			begin
				present_entry();
			end
			else
			begin
				hold_entry();
			end
		end
		valid = 1'b0;
		report = 1'b1;
		@(posedge clk);
		@(negedge clk);
		if (error_count == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule : tb_commit_stage

`default_nettype wire

//--- flist.f
source/lc3b_pkg.sv
source/commit_decode.sv
source/cc_unit.sv
source/commit_control.sv
source/commit_stage.sv
sim/commit_checker.sv
sim/tb_commit_stage.sv

//--- Makefile
# Verilator simulation of the commit stage

VERILATOR ?= verilator
TOP       ?= tb_commit_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the search for the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
